// File: run.sh
#!/bin/sh
# Build and run the LCD controller testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

echo "Building with Verilator"
verilator --binary --timing --assert -Wno-fatal \
   -f verilog.f --top-module lcd_tb -o lcd_sim
status=$?
if [ $status -ne 0 ]; then
   echo "Verilator build failed with status $status"
   exit 1
fi

echo "Running simulation"
./obj_dir/lcd_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
fi

if grep -q "All tests passed" "$LOG"; then
   echo "PASS"
   exit 0
else
   echo "FAIL"
   exit 1
fi

// File: src/lcd_bus_timing.sv
`include "lcd_config.svh"

module lcd_bus_timing (
   input  logic       clk,
   input  logic       rst,
   input  logic       xfer_req,
   input  logic       xfer_rs,
   input  logic [7:0] xfer_data,
   output logic       xfer_ack,
   output logic       lcd_rs,
   output logic       lcd_rw,
   output logic       lcd_en,
   output logic [7:0] lcd_data
);

   // Counter covers the longer of phase and clear wait
   localparam int CNT_MAX = (`LCD_CLEAR_WAIT > `LCD_PHASE_CYCLES) ?
                            `LCD_CLEAR_WAIT : `LCD_PHASE_CYCLES;
   localparam int CNT_W   = $clog2(CNT_MAX + 1);

   localparam logic [CNT_W-1:0] PHASE_LAST = CNT_W'(`LCD_PHASE_CYCLES - 1);
   localparam logic [CNT_W-1:0] WAIT_LAST  = CNT_W'(`LCD_CLEAR_WAIT - 1);

   // Bus phases
   localparam logic [2:0] P_IDLE   = 3'd0;
   localparam logic [2:0] P_SETUP  = 3'd1;
   localparam logic [2:0] P_ENABLE = 3'd2;
   localparam logic [2:0] P_HOLD   = 3'd3;
   localparam logic [2:0] P_WAIT   = 3'd4;
   localparam logic [2:0] P_ACK    = 3'd5;

   logic [2:0]       phase;
   logic [CNT_W-1:0] cnt;
   logic             is_clear;
   logic             accept;

   // Write-only panel
   assign lcd_rw = 1'b0;

   assign accept = (phase == P_IDLE) && xfer_req;

   // Data pins, loaded at the start of setup, held through hold
   always_ff @(posedge clk)
   begin
      if (accept)
         lcd_data <= xfer_data;
   end

   //////////////////////////////////////////////////
   // Phase sequencing
   //////////////////////////////////////////////////

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         phase    <= P_IDLE;
         cnt      <= '0;
         is_clear <= 1'b0;
         xfer_ack <= 1'b0;
         lcd_rs   <= 1'b0;
         lcd_en   <= 1'b0;
      end
      else
      begin
         case (phase)
            P_IDLE:
            begin
               if (accept)
               begin
                  lcd_rs   <= xfer_rs;
                  // Clear instruction needs the long wait
                  is_clear <= !xfer_rs && (xfer_data == 8'h01);
                  cnt      <= '0;
                  phase    <= P_SETUP;
               end
            end
            P_SETUP:
            begin
               cnt <= cnt + 1'b1;
               if (cnt == PHASE_LAST)
               begin
                  cnt    <= '0;
                  lcd_en <= 1'b1;
                  phase  <= P_ENABLE;
               end
            end
            P_ENABLE:
            begin
               cnt <= cnt + 1'b1;
               if (cnt == PHASE_LAST)
               begin
                  cnt    <= '0;
                  // Panel latches on this falling edge
                  lcd_en <= 1'b0;
                  phase  <= P_HOLD;
               end
            end
            P_HOLD:
            begin
               cnt <= cnt + 1'b1;
               if (cnt == PHASE_LAST)
               begin
                  cnt <= '0;
                  if (is_clear)
                     phase <= P_WAIT;
                  else
                  begin
                     xfer_ack <= 1'b1;
                     phase    <= P_ACK;
                  end
               end
            end
            P_WAIT:
            begin
               cnt <= cnt + 1'b1;
               if (cnt == WAIT_LAST)
               begin
                  cnt      <= '0;
                  xfer_ack <= 1'b1;
                  phase    <= P_ACK;
               end
            end
            default:
            begin
               // Close the four-phase handshake
               if (!xfer_req)
               begin
                  xfer_ack <= 1'b0;
                  phase    <= P_IDLE;
               end
            end
         endcase
      end
   end

endmodule

// File: src/lcd_config.svh
`ifndef LCD_CONFIG_SVH
`define LCD_CONFIG_SVH

//////////////////////////////////////////////////
// Panel bus timing
//////////////////////////////////////////////////

// Clock cycles in each of setup, enable-high and hold
// Small for simulation, raise for a real panel
`define LCD_PHASE_CYCLES 4

// Extra idle cycles after the clear instruction
// Clear is the slow instruction on HD44780 parts
`define LCD_CLEAR_WAIT 40

//////////////////////////////////////////////////
// Panel geometry
//////////////////////////////////////////////////

// Characters per row
`define LCD_COLS 16

// Rows on the panel
`define LCD_ROWS 2

`endif

// File: src/lcd_display_top.sv
module lcd_display_top (
   input  logic                   clk,
   input  logic                   rst,
   // Host port, four-phase
   input  logic                   host_req,
   input  logic                   host_cmd,
   input  lcd_pkg::lcd_host_word_u host_word,
   output logic                   host_ack,
   // Panel pins
   output logic                   lcd_rs,
   output logic                   lcd_rw,
   output logic                   lcd_en,
   output logic [7:0]             lcd_data
);

   //////////////////////////////////////////////////
   // Internal links
   //////////////////////////////////////////////////

   // Refresh read, buffer to sequencer
   logic [4:0] rd_addr;
   logic [7:0] rd_char;

   // Byte transfer, sequencer to bus timing
   logic       xfer_req;
   logic       xfer_ack;
   logic       xfer_rs;
   logic [7:0] xfer_data;

   lcd_text_buffer u_buffer (
      .clk       (clk),
      .rst       (rst),
      .host_req  (host_req),
      .host_cmd  (host_cmd),
      .host_word (host_word),
      .rd_addr   (rd_addr),
      .host_ack  (host_ack),
      .rd_char   (rd_char)
   );

   lcd_sequencer u_sequencer (
      .clk       (clk),
      .rst       (rst),
      .rd_char   (rd_char),
      .xfer_ack  (xfer_ack),
      .rd_addr   (rd_addr),
      .xfer_req  (xfer_req),
      .xfer_rs   (xfer_rs),
      .xfer_data (xfer_data)
   );

   lcd_bus_timing u_bus (
      .clk       (clk),
      .rst       (rst),
      .xfer_req  (xfer_req),
      .xfer_rs   (xfer_rs),
      .xfer_data (xfer_data),
      .xfer_ack  (xfer_ack),
      .lcd_rs    (lcd_rs),
      .lcd_rw    (lcd_rw),
      .lcd_en    (lcd_en),
      .lcd_data  (lcd_data)
   );

endmodule

// File: src/lcd_pkg.sv
package lcd_pkg;

   //////////////////////////////////////////////////
   // Host word layouts
   //////////////////////////////////////////////////

   // Character write, one cell at row and column
   typedef struct packed {
      logic       row;
      logic [3:0] col;
      logic [7:0] ch;
   } lcd_char_write_t;

   // Fill operations
   // Codes 2 and 3 are ignored by the buffer
   typedef enum logic [1:0] {
      fill_all = 2'd0,
      fill_row = 2'd1
   } lcd_fill_op_e;

   // Fill command, whole screen or one row
   typedef struct packed {
      lcd_fill_op_e op;
      logic         row;
      logic [1:0]   pad;
      logic [7:0]   ch;
   } lcd_fill_cmd_t;

   // Same 13 bits, decoded by host_cmd
   typedef union packed {
      lcd_char_write_t wr;
      lcd_fill_cmd_t   fill;
   } lcd_host_word_u;

   //////////////////////////////////////////////////
   // Sequencer
   //////////////////////////////////////////////////

   typedef enum logic [1:0] {
      st_init,
      st_line_addr,
      st_line_data
   } lcd_seq_state_e;

endpackage

// File: src/lcd_sequencer.sv
`include "lcd_config.svh"

module lcd_sequencer (
   input  logic       clk,
   input  logic       rst,
   input  logic [7:0] rd_char,
   input  logic       xfer_ack,
   output logic [4:0] rd_addr,
   output logic       xfer_req,
   output logic       xfer_rs,
   output logic [7:0] xfer_data
);
   import lcd_pkg::*;

   localparam logic [3:0] LAST_COL  = 4'(`LCD_COLS - 1);
   localparam logic [2:0] INIT_LAST = 3'd4;

   lcd_seq_state_e state;
   logic [2:0]     init_idx;
   logic           line;
   logic [3:0]     col;
   // Next byte to put on the transfer port
   logic           next_rs;
   logic [7:0]     next_data;
   logic           launch;
   logic           done;

   //////////////////////////////////////////////////
   // Power-up instruction table
   //////////////////////////////////////////////////

   function automatic logic [7:0] init_byte(input logic [2:0] idx);
      logic [7:0] b;
      case (idx)
         // Function set, 8-bit bus, two lines, 5x8 font
         3'd0:    b = 8'h38;
         // Display off
         3'd1:    b = 8'h08;
         // Clear
         3'd2:    b = 8'h01;
         // Entry mode, increment, no shift
         3'd3:    b = 8'h06;
         // Display on, cursor off
         default: b = 8'h0C;
      endcase
      return b;
   endfunction

   // Refresh read follows the position, so the next character
   // is fetched while the current transfer closes
   assign rd_addr = {line, col};

   // New transfer only once the previous one is fully closed
   assign launch = !xfer_req && !xfer_ack;
   // Ack seen, byte accepted
   assign done = xfer_req && xfer_ack;

   always_comb
   begin
      next_rs   = 1'b0;
      next_data = init_byte(init_idx);
      case (state)
         st_line_addr:
            // Set DDRAM address, 0x80 or 0xC0
            next_data = {1'b1, line, 6'd0};
         st_line_data:
         begin
            next_rs   = 1'b1;
            next_data = rd_char;
         end
         default:
            next_rs = 1'b0;
      endcase
   end

   // Transfer payload
   always_ff @(posedge clk)
   begin
      if (launch)
      begin
         xfer_rs   <= next_rs;
         xfer_data <= next_data;
      end
   end

   //////////////////////////////////////////////////
   // Init walk, then endless line refresh
   //////////////////////////////////////////////////

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         state    <= st_init;
         init_idx <= 3'd0;
         line     <= 1'b0;
         col      <= 4'd0;
         xfer_req <= 1'b0;
      end
      else if (launch)
         xfer_req <= 1'b1;
      else if (done)
      begin
         xfer_req <= 1'b0;
         case (state)
            st_init:
            begin
               if (init_idx == INIT_LAST)
               begin
                  line  <= 1'b0;
                  col   <= 4'd0;
                  state <= st_line_addr;
               end
               else
                  init_idx <= init_idx + 3'd1;
            end
            st_line_addr:
               state <= st_line_data;
            default:
            begin
               if (col == LAST_COL)
               begin
                  // Line done, switch to the other line
                  col   <= 4'd0;
                  line  <= ~line;
                  state <= st_line_addr;
               end
               else
                  col <= col + 4'd1;
            end
         endcase
      end
   end

endmodule

// File: src/lcd_text_buffer.sv
`include "lcd_config.svh"

module lcd_text_buffer (
   input  logic                   clk,
   input  logic                   rst,
   input  logic                   host_req,
   input  logic                   host_cmd,
   input  lcd_pkg::lcd_host_word_u host_word,
   input  logic [4:0]             rd_addr,
   output logic                   host_ack,
   output logic [7:0]             rd_char
);
   import lcd_pkg::*;

   localparam int         CELLS    = `LCD_COLS * `LCD_ROWS;
   localparam logic [3:0] LAST_COL = 4'(`LCD_COLS - 1);

   // Control states
   localparam logic [1:0] B_IDLE     = 2'd0;
   localparam logic [1:0] B_FILL     = 2'd1;
   localparam logic [1:0] B_ACK_SET  = 2'd2;
   localparam logic [1:0] B_ACK_WAIT = 2'd3;

   logic [7:0] mem [CELLS];
   logic       req_q;
   logic [1:0] state;
   // Fill engine
   logic       fill_host;
   logic [4:0] fill_addr;
   logic [4:0] fill_last;
   logic [7:0] fill_ch;
   // Single write port
   logic       mem_we;
   logic [4:0] mem_waddr;
   logic [7:0] mem_wdata;

   //////////////////////////////////////////////////
   // Write port select
   //////////////////////////////////////////////////

   always_comb
   begin
      mem_we    = 1'b0;
      mem_waddr = fill_addr;
      mem_wdata = fill_ch;
      if (state == B_FILL)
         mem_we = 1'b1;
      // Character write goes straight in, one cycle
      else if (state == B_IDLE && req_q && !host_cmd)
      begin
         mem_we    = 1'b1;
         mem_waddr = {host_word.wr.row, host_word.wr.col};
         mem_wdata = host_word.wr.ch;
      end
   end

   // Frame memory with registered refresh read
   always_ff @(posedge clk)
   begin
      if (mem_we)
         mem[mem_waddr] <= mem_wdata;
      rd_char <= mem[rd_addr];
   end

   //////////////////////////////////////////////////
   // Host handshake and fill engine
   //////////////////////////////////////////////////

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         req_q     <= 1'b0;
         host_ack  <= 1'b0;
         // Power-up clear of the screen to spaces
         state     <= B_FILL;
         fill_host <= 1'b0;
         fill_addr <= 5'd0;
         fill_last <= 5'(CELLS - 1);
         fill_ch   <= 8'h20;
      end
      else
      begin
         // Host request sampled once, held off during a fill
         req_q <= host_req;
         case (state)
            B_IDLE:
            begin
               if (req_q)
               begin
                  if (!host_cmd)
                     state <= B_ACK_SET;
                  else if (host_word.fill.op == fill_all)
                  begin
                     fill_addr <= 5'd0;
                     fill_last <= 5'(CELLS - 1);
                     fill_ch   <= host_word.fill.ch;
                     fill_host <= 1'b1;
                     state     <= B_FILL;
                  end
                  else if (host_word.fill.op == fill_row)
                  begin
                     fill_addr <= {host_word.fill.row, 4'd0};
                     fill_last <= {host_word.fill.row, LAST_COL};
                     fill_ch   <= host_word.fill.ch;
                     fill_host <= 1'b1;
                     state     <= B_FILL;
                  end
                  // Unknown op, acked with no effect
                  else
                     state <= B_ACK_SET;
               end
            end
            B_FILL:
            begin
               if (fill_addr == fill_last)
                  state <= fill_host ? B_ACK_SET : B_IDLE;
               else
                  fill_addr <= fill_addr + 5'd1;
            end
            B_ACK_SET:
            begin
               host_ack <= 1'b1;
               state    <= B_ACK_WAIT;
            end
            default:
            begin
               // Wait for the host to let go
               if (!req_q)
               begin
                  host_ack <= 1'b0;
                  state    <= B_IDLE;
               end
            end
         endcase
      end
   end

endmodule

// File: tb/lcd_asserts.sv
module lcd_asserts (
   input logic       clk,
   input logic       rst,
   input logic       host_req,
   input logic       host_ack,
   input logic       xfer_req,
   input logic       xfer_ack,
   input logic       lcd_rs,
   input logic       lcd_rw,
   input logic       lcd_en,
   input logic [7:0] lcd_data
);

   //////////////////////////////////////////////////
   // Host port handshake
   //////////////////////////////////////////////////

   // Ack only answers a request
   assert property (@(posedge clk) disable iff (rst) $rose(host_ack) |-> host_req)
      else $error("host_ack rose without host_req");
   // Request held until answered
   assert property (@(posedge clk) disable iff (rst) host_req && !host_ack |=> host_req)
      else $error("host_req dropped before host_ack");
   assert property (@(posedge clk) disable iff (rst) $fell(host_ack) |-> !host_req)
      else $error("host_ack fell while host_req high");

   //////////////////////////////////////////////////
   // Byte transfer handshake
   //////////////////////////////////////////////////

   assert property (@(posedge clk) disable iff (rst) $rose(xfer_ack) |-> xfer_req)
      else $error("xfer_ack rose without xfer_req");
   assert property (@(posedge clk) disable iff (rst) xfer_req && !xfer_ack |=> xfer_req)
      else $error("xfer_req dropped before xfer_ack");

   // Panel pins, data and RS frozen while E is high
   assert property (@(posedge clk) disable iff (rst)
                    lcd_en |-> $stable(lcd_data) && $stable(lcd_rs))
      else $error("lcd_data or lcd_rs changed while lcd_en high");
   // Write-only panel
   assert property (@(posedge clk) disable iff (rst) !lcd_rw)
      else $error("lcd_rw went high");

endmodule

bind lcd_display_top lcd_asserts u_asserts (
   .clk      (clk),
   .rst      (rst),
   .host_req (host_req),
   .host_ack (host_ack),
   .xfer_req (xfer_req),
   .xfer_ack (xfer_ack),
   .lcd_rs   (lcd_rs),
   .lcd_rw   (lcd_rw),
   .lcd_en   (lcd_en),
   .lcd_data (lcd_data)
);

// File: tb/lcd_tb.sv
`include "lcd_config.svh"

module lcd_tb;
   import lcd_pkg::*;

   //////////////////////////////////////////////////
   // Run length
   //////////////////////////////////////////////////

   // Frames waited by the tests, one in test 2 and two in each later test
   localparam int     WAIT_FRAMES   = 9;
   // Two address bytes and 32 data bytes, plus the init table
   localparam int     FRAME_BYTES   = 34 + 5;
   localparam longint WATCHDOG_TIME = longint'((WAIT_FRAMES + 3) * FRAME_BYTES * 3
                                      * `LCD_PHASE_CYCLES * 10 * 2 + `LCD_CLEAR_WAIT * 10);

   logic           clk;
   logic           rst;
   logic           host_req;
   logic           host_cmd;
   lcd_host_word_u host_word;
   logic           host_ack;
   logic           lcd_rs;
   logic           lcd_rw;
   logic           lcd_en;
   logic [7:0]     lcd_data;

   // Panel model state
   logic [8:0]     captured [$];
   logic [7:0]     ddram [128];
   logic [6:0]     ddram_addr;
   int             frames = 0;
   // Expected screen, tracked from the host commands
   logic [7:0]     exp_mem [32];
   int             ack_count = 0;
   logic           ack_q = 1'b0;
   logic [15:0]    lfsr;

   lcd_display_top uut (
      .clk       (clk),
      .rst       (rst),
      .host_req  (host_req),
      .host_cmd  (host_cmd),
      .host_word (host_word),
      .host_ack  (host_ack),
      .lcd_rs    (lcd_rs),
      .lcd_rw    (lcd_rw),
      .lcd_en    (lcd_en),
      .lcd_data  (lcd_data)
   );

   initial clk = 1'b0;
   always #5 clk = ~clk;

   //////////////////////////////////////////////////
   // Panel model, latches on the falling edge of E
   //////////////////////////////////////////////////

   always @(negedge lcd_en)
   begin
      if (!rst)
      begin
         // Write-only bus, RW must be low at the latch
         if (lcd_rw !== 1'b0)
            stop_on_error("lcd_rw not low when the panel latched a byte");
         captured.push_back({lcd_rs, lcd_data});
         // Set DDRAM address
         if (!lcd_rs && lcd_data[7])
            ddram_addr = lcd_data[6:0];
         // Clear homes the address counter
         else if (!lcd_rs && lcd_data == 8'h01)
            ddram_addr = 7'd0;
         else if (lcd_rs)
         begin
            ddram[ddram_addr] = lcd_data;
            // Last cell of line two closes a frame
            if (ddram_addr == 7'h4F)
               frames = frames + 1;
            ddram_addr = ddram_addr + 7'd1;
         end
      end
   end

   // Ack rising edges, one per host transfer
   always @(posedge clk)
   begin
      ack_q <= host_ack;
      if (host_ack && !ack_q)
         ack_count <= ack_count + 1;
   end

   // Watchdog
   initial
   begin
      #(WATCHDOG_TIME);
      $display("Watchdog expired before the tests finished");
      $display("Some tests failed");
      $fatal(1, "Timeout");
   end

   //////////////////////////////////////////////////
   // Random numbers and checks
   //////////////////////////////////////////////////

   // Galois LFSR, taps 16 14 13 11
   function automatic logic [15:0] lfsr_step(input logic [15:0] s);
      return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
   endfunction

   // One LFSR step per bit taken
   function automatic logic [7:0] take_bits(input int n);
      logic [7:0] v;
      int         i;
      v = 8'd0;
      for (i = 0; i < n; i++)
      begin
         lfsr = lfsr_step(lfsr);
         v    = {v[6:0], lfsr[0]};
      end
      return v;
   endfunction

   task automatic stop_on_error(input string msg);
      $display("Error at %0t: %s", $time, msg);
      $display("Some tests failed");
      $fatal(1, "Check failed");
   endtask

   task automatic check_byte(input int idx, input logic exp_rs, input logic [7:0] exp_data);
      if (captured[idx] !== {exp_rs, exp_data})
         stop_on_error($sformatf("byte %0d rs=%0b data=0x%02h, expected rs=%0b data=0x%02h",
                                 idx, captured[idx][8], captured[idx][7:0], exp_rs, exp_data));
   endtask

   task automatic check_char(input lcd_char_write_t exp);
      logic [7:0] got;
      got = ddram[{exp.row, 2'b00, exp.col}];
      if (got !== exp.ch)
         stop_on_error($sformatf("cell row %0d col %0d holds 0x%02h, expected 0x%02h",
                                 exp.row, exp.col, got, exp.ch));
   endtask

   task automatic check_count(input int got, input int exp, input string what);
      if (got != exp)
         stop_on_error($sformatf("%s count %0d, expected %0d", what, got, exp));
   endtask

   //////////////////////////////////////////////////
   // Host port and helpers
   //////////////////////////////////////////////////

   // One four-phase transfer
   task automatic send_host_word(input logic cmd, input lcd_host_word_u w);
      @(posedge clk);
      host_req  <= 1'b1;
      host_cmd  <= cmd;
      host_word <= w;
      do
         @(posedge clk);
      while (!host_ack);
      host_req <= 1'b0;
      do
         @(posedge clk);
      while (host_ack);
   endtask

   task automatic write_char(input logic row, input logic [3:0] col, input logic [7:0] ch);
      lcd_host_word_u w;
      w.wr.row = row;
      w.wr.col = col;
      w.wr.ch  = ch;
      send_host_word(1'b0, w);
      exp_mem[{row, col}] = ch;
   endtask

   task automatic write_random_char(input logic only_row0);
      logic [7:0] r;
      logic [7:0] c;
      logic [7:0] ch;
      r  = take_bits(1);
      c  = take_bits(4);
      ch = take_bits(8);
      write_char(only_row0 ? 1'b0 : r[0], c[3:0], ch);
   endtask

   task automatic fill_cells(input lcd_fill_op_e op, input logic row, input logic [7:0] ch);
      lcd_host_word_u w;
      int             i;
      w.fill.op  = op;
      w.fill.row = row;
      w.fill.pad = 2'b00;
      w.fill.ch  = ch;
      send_host_word(1'b1, w);
      for (i = 0; i < 32; i++)
         if (op == fill_all || (i >= 16) == row)
            exp_mem[i] = ch;
   endtask

   task automatic wait_frames(input int n);
      int target;
      target = frames + n;
      while (frames < target)
         @(posedge clk);
   endtask

   // Whole model DDRAM against the expected screen
   task automatic check_screen();
      lcd_char_write_t c;
      int              i;
      for (i = 0; i < 32; i++)
      begin
         c.row = (i >= 16);
         c.col = 4'(i % 16);
         c.ch  = exp_mem[i];
         check_char(c);
      end
   endtask

   //////////////////////////////////////////////////
   // Tests
   //////////////////////////////////////////////////

   task automatic test_init_sequence();
      while (captured.size() < 5)
         @(posedge clk);
      check_byte(0, 1'b0, 8'h38);
      check_byte(1, 1'b0, 8'h08);
      check_byte(2, 1'b0, 8'h01);
      check_byte(3, 1'b0, 8'h06);
      check_byte(4, 1'b0, 8'h0C);
   endtask

   task automatic test_first_refresh();
      int i;
      while (frames < 1)
         @(posedge clk);
      // Line one, then line two
      check_byte(5, 1'b0, 8'h80);
      for (i = 0; i < 16; i++)
         check_byte(6 + i, 1'b1, 8'h20);
      check_byte(22, 1'b0, 8'hC0);
      for (i = 0; i < 16; i++)
         check_byte(23 + i, 1'b1, 8'h20);
      check_screen();
   endtask

   task automatic test_random_writes();
      repeat (20)
         write_random_char(1'b0);
      wait_frames(2);
      check_screen();
   endtask

   task automatic test_fill_all();
      fill_cells(fill_all, 1'b0, take_bits(8));
      wait_frames(2);
      check_screen();
   endtask

   task automatic test_fill_row();
      // Distinct contents on line one first
      repeat (4)
         write_random_char(1'b1);
      fill_cells(fill_row, 1'b1, take_bits(8));
      wait_frames(2);
      check_screen();
   endtask

   task automatic test_back_to_back();
      int start;
      start = ack_count;
      repeat (10)
         write_random_char(1'b0);
      wait_frames(2);
      check_count(ack_count - start, 10, "host ack");
      check_screen();
   endtask

   initial
   begin
      int i;
      host_req   = 1'b0;
      host_cmd   = 1'b0;
      host_word  = '0;
      rst        = 1'b1;
      lfsr       = 16'd36951;
      ddram_addr = 7'd0;
      for (i = 0; i < 128; i++)
         ddram[i] = 8'h00;
      // Buffer is filled with spaces at reset
      for (i = 0; i < 32; i++)
         exp_mem[i] = 8'h20;
      repeat (2) @(posedge clk);
      rst <= 1'b0;
      test_init_sequence();
      test_first_refresh();
      test_random_writes();
      test_fill_all();
      test_fill_row();
      test_back_to_back();
      $display("All tests passed");
      $finish;
   end

endmodule

// File: verilog.f
+incdir+src
src/lcd_pkg.sv
src/lcd_text_buffer.sv
src/lcd_bus_timing.sv
src/lcd_sequencer.sv
src/lcd_display_top.sv
tb/lcd_asserts.sv
tb/lcd_tb.sv
